// File: Makefile
# Verilator build and run for the flux analyser host core

VERILATOR ?= verilator
TOP       ?= fdd_tb
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FLIST     ?= sim.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FLIST))
HDRS := src/fdd_settings.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source, the header or the file list changes
$(BIN): $(FLIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@! grep -q "Errors found" $(LOG)
	@grep -q "No errors" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: sim.f
+incdir+src
src/fdd_pkg.sv
src/tick_gen.sv
src/mcu_regs.sv
src/sram_addr_counter.sv
src/sram_write_ctrl.sv
src/index_meter.sv
src/step_ctrl.sv
src/fdd_top.sv
tests/fdd_assert.sv
tests/fdd_checker.sv
tests/fdd_tb.sv

// File: src/fdd_pkg.sv
package fdd_pkg;

	// SRAM address, loaded bytewise by the host but counted as one word
	typedef union packed {
		logic [23:0] word;
		struct packed {
			logic [7:0] upper;		// Only bits 2..0 used
			logic [7:0] high;
			logic [7:0] low;
		} bytes;
	} sram_addr_u;

	// Head step command byte
	typedef union packed {
		logic [7:0] raw;
		struct packed {
			logic       dir;		// 1 = inward
			logic [6:0] count;		// Number of steps
		} cmd;
	} step_cmd_u;

	// Index period in 10us ticks
	typedef union packed {
		logic [15:0] count;
		struct packed {
			logic [7:0] hi;
			logic [7:0] lo;
		} bytes;
	} index_count_u;

endpackage

// File: src/fdd_settings.svh
`ifndef FDD_SETTINGS_SVH
`define FDD_SETTINGS_SVH

////////////////////////////////////////////////////////////////////////////
// Clocking

`define CLK_MASTER_FREQ		100_000_000					// Master clock in Hz

// Half of the 500us period, so two step ticks per period
`define TICK_250US_DIV		(`CLK_MASTER_FREQ / 4_000)
`define TICK_10US_DIV		(`CLK_MASTER_FREQ / 100_000)	// Index reference tick

////////////////////////////////////////////////////////////////////////////
// Host register map, low address byte only

`define REG_ADDR_LOW		8'h00		// SRAM address bits 7..0
`define REG_ADDR_HIGH		8'h01		// SRAM address bits 15..8
`define REG_ADDR_UPPER		8'h02		// SRAM address bits 18..16
`define REG_SRAM_DATA		8'h03		// SRAM data port
`define REG_DRIVE_CTL		8'h04		// Write only, ID bytes read back from here up
`define REG_STATUS1			8'h0E
`define REG_STATUS2			8'h0F
`define REG_SCRATCH			8'h30
`define REG_SCRATCH_INV		8'h31
`define REG_FIXED_55		8'h32
`define REG_FIXED_AA		8'h33
`define REG_INDEX_HI		8'h40		// Read latches the low byte
`define REG_INDEX_LO		8'h41
`define REG_STEP_RATE		8'hF0		// Step rate, 250us units minus one
`define REG_STEP_CMD		8'hFF		// Direction in MSB, step count below

`define MCO_TYPE			16'hDD55	// Microcode type
`define MCO_VERSION			16'h0028	// Microcode version

`define FIFO_DEPTH_LOG2		3			// Host write FIFO, 8 entries

`endif

// File: src/fdd_top.sv
`timescale 1ns/100ps

module fdd_top import fdd_pkg::*; (
	input  logic        CLK_MASTER,
	input  logic        arst_n,
	// MCU parallel bus
	input  logic [7:0]  mcu_pmd_in,
	output logic [7:0]  mcu_pmd_out,		// Enabled on the board while mcu_pmrd high
	input  logic        mcu_pmall,
	input  logic        mcu_pmwr,
	input  logic        mcu_pmrd,
	// SRAM
	output logic [18:0] sram_a,
	input  logic [7:0]  sram_dq_in,
	output logic [7:0]  sram_dq_out,		// Driven onto the bus while sram_oe_n high
	output logic        sram_we_n,
	output logic        sram_oe_n,
	// Floppy drive
	output logic        fd_dens_out,
	output logic        fd_inuse,
	output logic [3:0]  fd_drvsel,
	output logic        fd_moten,
	output logic        fd_sidesel,
	output logic        fd_dir,
	output logic        fd_step_n,
	input  logic        fd_index_in,
	input  logic        fd_track0_in,
	input  logic        fd_wrprot_in,
	input  logic        fd_rdy_in,
	input  logic        fd_dens_in
);

	logic         tick_250us, tick_10us;
	logic [2:0]   addr_load;					// {upper, high, low}
	logic         data_push, rd_done, index_hi_rd, step_cmd_wr;
	logic [7:0]   step_rate;
	logic         addr_empty, addr_full;
	logic         fifo_busy, incr;
	logic         is_stepping, track0_hit;
	logic         new_index;
	index_count_u index_count;
	logic [7:0]   index_lo;

	////////////////////////////////////////////////////////////////////////////
	// Timebase and host interface

	tick_gen u_tick_gen (
		.CLK_MASTER	(CLK_MASTER),
		.arst_n		(arst_n),
		.tick_250us	(tick_250us),
		.tick_10us	(tick_10us)
	);

	mcu_regs u_mcu_regs (
		.CLK_MASTER		(CLK_MASTER),
		.arst_n			(arst_n),
		.mcu_pmd_in		(mcu_pmd_in),
		.mcu_pmd_out	(mcu_pmd_out),
		.mcu_pmall		(mcu_pmall),
		.mcu_pmwr		(mcu_pmwr),
		.mcu_pmrd		(mcu_pmrd),
		.sram_a			(sram_a),
		.sram_dq_in		(sram_dq_in),
		.addr_empty		(addr_empty),
		.addr_full		(addr_full),
		.fifo_busy		(fifo_busy),
		.is_stepping	(is_stepping),
		.track0_hit		(track0_hit),
		.new_index		(new_index),
		.index_count	(index_count),
		.index_lo		(index_lo),
		.fd_index_in	(fd_index_in),
		.fd_track0_in	(fd_track0_in),
		.fd_wrprot_in	(fd_wrprot_in),
		.fd_rdy_in		(fd_rdy_in),
		.fd_dens_in		(fd_dens_in),
		.addr_load		(addr_load),
		.data_push		(data_push),
		.rd_done		(rd_done),
		.index_hi_rd	(index_hi_rd),
		.step_cmd_wr	(step_cmd_wr),
		.step_rate		(step_rate),
		.fd_dens_out	(fd_dens_out),
		.fd_inuse		(fd_inuse),
		.fd_drvsel		(fd_drvsel),
		.fd_moten		(fd_moten),
		.fd_sidesel		(fd_sidesel)
	);

	////////////////////////////////////////////////////////////////////////////
	// SRAM path

	sram_addr_counter u_addr_counter (
		.CLK_MASTER	(CLK_MASTER),
		.arst_n		(arst_n),
		.addr_load	(addr_load),
		.load_byte	(mcu_pmd_in),
		.addr_inc	(incr | rd_done),			// Step on after each write or read
		.sram_a		(sram_a),
		.addr_empty	(addr_empty),
		.addr_full	(addr_full)
	);

	sram_write_ctrl u_write_ctrl (
		.CLK_MASTER		(CLK_MASTER),
		.arst_n			(arst_n),
		.data_push		(data_push),
		.push_byte		(mcu_pmd_in),
		.sram_dq_out	(sram_dq_out),
		.sram_we_n		(sram_we_n),
		.sram_oe_n		(sram_oe_n),
		.incr			(incr),
		.fifo_busy		(fifo_busy)
	);

	////////////////////////////////////////////////////////////////////////////
	// Drive side

	index_meter u_index_meter (
		.CLK_MASTER		(CLK_MASTER),
		.arst_n			(arst_n),
		.fd_index_in	(fd_index_in),
		.tick_10us		(tick_10us),
		.index_hi_rd	(index_hi_rd),
		.index_count	(index_count),
		.index_lo		(index_lo),
		.new_index		(new_index)
	);

	step_ctrl u_step_ctrl (
		.CLK_MASTER		(CLK_MASTER),
		.arst_n			(arst_n),
		.tick_250us		(tick_250us),
		.step_rate		(step_rate),
		.step_cmd_wr	(step_cmd_wr),
		.cmd_byte		(mcu_pmd_in),
		.fd_track0_in	(fd_track0_in),
		.fd_step_n		(fd_step_n),
		.fd_dir			(fd_dir),
		.is_stepping	(is_stepping),
		.track0_hit		(track0_hit)
	);

endmodule

// File: src/index_meter.sv
`timescale 1ns/100ps

module index_meter import fdd_pkg::*; (
	input  logic         CLK_MASTER,
	input  logic         arst_n,
	input  logic         fd_index_in,
	input  logic         tick_10us,
	input  logic         index_hi_rd,
	output index_count_u index_count,	// Last full period
	output logic [7:0]   index_lo,
	output logic         new_index
);

	logic [1:0]   idx_sync;			// Two-flop synchroniser
	logic         idx_prev;
	logic         idx_rise;
	index_count_u period_cnt;		// Running count of 10us ticks

	assign idx_rise = idx_sync[1] & ~idx_prev;

	always_ff @(posedge CLK_MASTER or negedge arst_n) begin
		if (!arst_n) begin
			idx_sync          <= '0;
			idx_prev          <= 1'b0;
			period_cnt.count  <= '0;
			index_count.count <= '0;
			new_index         <= 1'b0;
		end else begin
			idx_sync <= {idx_sync[0], fd_index_in};
			idx_prev <= idx_sync[1];
			if (idx_rise) begin
				index_count      <= period_cnt;		// Save and restart
				period_cnt.count <= '0;
			end else if (tick_10us) begin
				period_cnt.count <= period_cnt.count + 16'd1;
			end
			// High byte read clears, even with an edge in the same cycle
			if (index_hi_rd)
				new_index <= 1'b0;
			else if (idx_rise)
				new_index <= 1'b1;
		end
	end

	// Low byte held so a high-then-low read gives one measurement
	always_ff @(posedge CLK_MASTER) begin
		if (index_hi_rd)
			index_lo <= index_count.bytes.lo;
	end

endmodule

// File: src/mcu_regs.sv
`timescale 1ns/100ps
`include "fdd_settings.svh"

module mcu_regs import fdd_pkg::*; (
	input  logic         CLK_MASTER,
	input  logic         arst_n,
	input  logic [7:0]   mcu_pmd_in,
	output logic [7:0]   mcu_pmd_out,
	input  logic         mcu_pmall,
	input  logic         mcu_pmwr,
	input  logic         mcu_pmrd,
	input  logic [18:0]  sram_a,
	input  logic [7:0]   sram_dq_in,
	input  logic         addr_empty,
	input  logic         addr_full,
	input  logic         fifo_busy,
	input  logic         is_stepping,
	input  logic         track0_hit,
	input  logic         new_index,
	input  index_count_u index_count,
	input  logic [7:0]   index_lo,
	input  logic         fd_index_in,
	input  logic         fd_track0_in,
	input  logic         fd_wrprot_in,
	input  logic         fd_rdy_in,
	input  logic         fd_dens_in,
	output logic [2:0]   addr_load,		// {upper, high, low}
	output logic         data_push,
	output logic         rd_done,
	output logic         index_hi_rd,
	output logic         step_cmd_wr,
	output logic [7:0]   step_rate,
	output logic         fd_dens_out,
	output logic         fd_inuse,
	output logic [3:0]   fd_drvsel,
	output logic         fd_moten,
	output logic         fd_sidesel
);

	localparam logic [15:0] mco_type = `MCO_TYPE;
	localparam logic [15:0] mco_ver  = `MCO_VERSION;

	logic [7:0] addr_q;				// Latched register address
	logic [1:0] wr_s, rd_s;			// Strobe history
	logic       wr_pulse, rd_pulse;
	logic [7:0] drive_ctl, scratch;
	logic [7:0] sram_lat;			// SRAM data held for read-back
	sram_addr_u addr_view;

	assign addr_view.word = {5'd0, sram_a};

	////////////////////////////////////////////////////////////////////////////
	// Address latch and strobe edges

	always_ff @(posedge CLK_MASTER or negedge arst_n) begin
		if (!arst_n) begin
			addr_q   <= '0;
			wr_s     <= '0;
			rd_s     <= '0;
			wr_pulse <= 1'b0;
			rd_pulse <= 1'b0;
			rd_done  <= 1'b0;
		end else begin
			if (mcu_pmall)
				addr_q <= mcu_pmd_in;
			wr_s     <= {wr_s[0], mcu_pmwr};
			rd_s     <= {rd_s[0], mcu_pmrd};
			wr_pulse <= wr_s[0] & ~wr_s[1];		// Rising edges
			rd_pulse <= rd_s[0] & ~rd_s[1];
			// Falling read strobe on the data port steps the address
			rd_done  <= rd_s[1] & ~rd_s[0] & (addr_q == `REG_SRAM_DATA);
		end
	end

	// Write pulses to the other blocks
	assign addr_load[0] = wr_pulse && (addr_q == `REG_ADDR_LOW);
	assign addr_load[1] = wr_pulse && (addr_q == `REG_ADDR_HIGH);
	assign addr_load[2] = wr_pulse && (addr_q == `REG_ADDR_UPPER);
	assign data_push    = wr_pulse && (addr_q == `REG_SRAM_DATA);
	assign step_cmd_wr  = wr_pulse && (addr_q == `REG_STEP_CMD);
	assign index_hi_rd  = rd_pulse && (addr_q == `REG_INDEX_HI);

	////////////////////////////////////////////////////////////////////////////
	// Local registers

	always_ff @(posedge CLK_MASTER or negedge arst_n) begin
		if (!arst_n) begin
			drive_ctl <= '0;
			scratch   <= '0;
			step_rate <= '0;
		end else if (wr_pulse) begin
			case (addr_q)
				`REG_DRIVE_CTL: drive_ctl <= mcu_pmd_in;
				`REG_SCRATCH:   scratch   <= mcu_pmd_in;
				`REG_STEP_RATE: step_rate <= mcu_pmd_in;
				default: ;
			endcase
		end
	end

	// Track SRAM output, freeze while the read is taken
	always_ff @(posedge CLK_MASTER) begin
		if (!rd_pulse)
			sram_lat <= sram_dq_in;
	end

	// Drive outputs are active low
	assign fd_dens_out = ~drive_ctl[0];
	assign fd_inuse    = ~drive_ctl[1];
	assign fd_drvsel   = ~drive_ctl[5:2];
	assign fd_moten    = ~drive_ctl[6];
	assign fd_sidesel  = ~drive_ctl[7];

	////////////////////////////////////////////////////////////////////////////
	// Read-back mux

	always_comb begin
		case (addr_q)
			`REG_ADDR_LOW:           mcu_pmd_out = addr_view.bytes.low;
			`REG_ADDR_HIGH:          mcu_pmd_out = addr_view.bytes.high;
			`REG_ADDR_UPPER:         mcu_pmd_out = addr_view.bytes.upper;
			`REG_SRAM_DATA:          mcu_pmd_out = sram_lat;
			`REG_DRIVE_CTL:          mcu_pmd_out = mco_type[7:0];	// ID bytes
			`REG_DRIVE_CTL + 8'd1:   mcu_pmd_out = mco_type[15:8];
			`REG_DRIVE_CTL + 8'd2:   mcu_pmd_out = mco_ver[7:0];
			`REG_DRIVE_CTL + 8'd3:   mcu_pmd_out = mco_ver[15:8];
			`REG_STATUS1:            mcu_pmd_out = {3'b000, track0_hit, new_index,
				2'b00, fifo_busy};
			`REG_STATUS2:            mcu_pmd_out = {fd_index_in, fd_track0_in, fd_wrprot_in,
				fd_rdy_in, fd_dens_in, is_stepping, addr_empty, addr_full};
			`REG_SCRATCH:            mcu_pmd_out = scratch;
			`REG_SCRATCH_INV:        mcu_pmd_out = ~scratch;
			`REG_FIXED_55:           mcu_pmd_out = 8'h55;
			`REG_FIXED_AA:           mcu_pmd_out = 8'hAA;
			`REG_INDEX_HI:           mcu_pmd_out = index_count.bytes.hi;
			`REG_INDEX_LO:           mcu_pmd_out = index_lo;		// Latched by the high read
			default:                 mcu_pmd_out = 8'h00;
		endcase
	end

endmodule

// File: src/sram_addr_counter.sv
`timescale 1ns/100ps

module sram_addr_counter import fdd_pkg::*; (
	input  logic        CLK_MASTER,
	input  logic        arst_n,
	input  logic [2:0]  addr_load,		// {upper, high, low}
	input  logic [7:0]  load_byte,
	input  logic        addr_inc,
	output logic [18:0] sram_a,
	output logic        addr_empty,
	output logic        addr_full
);

	sram_addr_u addr_q;

	always_ff @(posedge CLK_MASTER or negedge arst_n) begin
		if (!arst_n) begin
			addr_q.word <= '0;
		end else if (|addr_load) begin
			// Host load wins over increment
			if (addr_load[0])
				addr_q.bytes.low <= load_byte;
			if (addr_load[1])
				addr_q.bytes.high <= load_byte;
			if (addr_load[2])
				addr_q.bytes.upper <= {5'd0, load_byte[2:0]};	// 19-bit address
		end else if (addr_inc) begin
			addr_q.word <= {5'd0, addr_q.word[18:0] + 19'd1};	// Wraps at 512K
		end
	end

	assign sram_a     = addr_q.word[18:0];
	assign addr_empty = (addr_q.word[18:0] == '0);
	assign addr_full  = &addr_q.word[18:0];		// Last location

endmodule

// File: src/sram_write_ctrl.sv
`timescale 1ns/100ps
`include "fdd_settings.svh"

module sram_write_ctrl (
	input  logic       CLK_MASTER,
	input  logic       arst_n,
	input  logic       data_push,
	input  logic [7:0] push_byte,
	output logic [7:0] sram_dq_out,
	output logic       sram_we_n,
	output logic       sram_oe_n,
	output logic       incr,			// Address step request
	output logic       fifo_busy
);

	localparam int depth = 1 << `FIFO_DEPTH_LOG2;

	localparam logic [2:0] s_idle   = 3'd0;		// Waiting for data
	localparam logic [2:0] s_oe_off = 3'd1;		// SRAM outputs off, FIFO pops
	localparam logic [2:0] s_write  = 3'd2;		// WE low
	localparam logic [2:0] s_wr_end = 3'd3;
	localparam logic [2:0] s_incr   = 3'd4;

	logic [7:0]                  fifo_mem [depth];
	logic [`FIFO_DEPTH_LOG2-1:0] wr_ptr, rd_ptr;
	logic [`FIFO_DEPTH_LOG2:0]   fill;
	logic                        fifo_empty, fifo_full, push_ok, pop;
	logic [2:0]                  state, nxt;

	assign fifo_empty = (fill == '0);
	assign fifo_full  = fill[`FIFO_DEPTH_LOG2];		// Only set at full depth
	assign push_ok    = data_push && !fifo_full;		// Push when full is lost
	assign pop        = (state == s_oe_off);
	assign fifo_busy  = !fifo_empty || (state != s_idle);

	always_comb begin
		case (state)
			s_idle:   nxt = fifo_empty ? s_idle : s_oe_off;
			s_oe_off: nxt = s_write;
			s_write:  nxt = s_wr_end;
			s_wr_end: nxt = s_incr;
			default:  nxt = s_idle;
		endcase
	end

	// FIFO storage and output byte
	always_ff @(posedge CLK_MASTER) begin
		if (push_ok)
			fifo_mem[wr_ptr] <= push_byte;
		if (pop)
			sram_dq_out <= fifo_mem[rd_ptr];		// Stable through write and write-end
	end

	always_ff @(posedge CLK_MASTER or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			fill      <= '0;
			state     <= s_idle;
			sram_we_n <= 1'b1;
			sram_oe_n <= 1'b0;
			incr      <= 1'b0;
		end else begin
			if (push_ok)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push_ok, pop})
				2'b10:   fill <= fill + 1'b1;
				2'b01:   fill <= fill - 1'b1;
				default: ;
			endcase
			state     <= nxt;
			// Strobes follow the state they belong to
			sram_we_n <= (nxt != s_write);
			sram_oe_n <= (nxt != s_idle);
			incr      <= (nxt == s_incr);
		end
	end

endmodule

// File: src/step_ctrl.sv
`timescale 1ns/100ps

module step_ctrl import fdd_pkg::*; (
	input  logic       CLK_MASTER,
	input  logic       arst_n,
	input  logic       tick_250us,
	input  logic [7:0] step_rate,
	input  logic       step_cmd_wr,
	input  logic [7:0] cmd_byte,
	input  logic       fd_track0_in,
	output logic       fd_step_n,
	output logic       fd_dir,
	output logic       is_stepping,
	output logic       track0_hit		// Seek stopped at track 0
);

	step_cmd_u  cmd;
	logic [7:0] rate_cnt;
	logic       step_clk;			// Divided step clock
	logic       clk_flip;			// Step clock toggles this cycle
	logic [6:0] steps_left;
	logic [1:0] trk0_sync;

	assign cmd.raw     = cmd_byte;
	assign clk_flip    = tick_250us && (rate_cnt == step_rate);
	assign is_stepping = (steps_left != 7'd0) || !fd_step_n;	// Includes last pulse

	////////////////////////////////////////////////////////////////////////////
	// Step rate divider, toggles every step_rate + 1 ticks

	always_ff @(posedge CLK_MASTER or negedge arst_n) begin
		if (!arst_n) begin
			rate_cnt  <= '0;
			step_clk  <= 1'b0;
			trk0_sync <= '0;
		end else begin
			trk0_sync <= {trk0_sync[0], fd_track0_in};
			if (clk_flip) begin
				rate_cnt <= '0;
				step_clk <= ~step_clk;
			end else if (tick_250us) begin
				rate_cnt <= rate_cnt + 8'd1;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Stepping FSM, one pulse per rising step clock

	always_ff @(posedge CLK_MASTER or negedge arst_n) begin
		if (!arst_n) begin
			fd_step_n  <= 1'b1;
			fd_dir     <= 1'b0;
			steps_left <= '0;
			track0_hit <= 1'b0;
		end else if (step_cmd_wr) begin
			fd_dir     <= cmd.cmd.dir;
			steps_left <= cmd.cmd.count;
			track0_hit <= 1'b0;				// New seek clears the flag
		end else if (clk_flip && step_clk) begin
			fd_step_n  <= 1'b1;				// Falling toggle ends the pulse
		end else if (clk_flip && steps_left != 7'd0) begin
			if (!fd_dir && trk0_sync[1]) begin
				track0_hit <= 1'b1;			// Outward at track 0, abandon the rest
				steps_left <= '0;
			end else begin
				fd_step_n  <= 1'b0;
				steps_left <= steps_left - 7'd1;
			end
		end
	end

endmodule

// File: src/tick_gen.sv
`timescale 1ns/100ps
`include "fdd_settings.svh"

module tick_gen (
	input  logic CLK_MASTER,
	input  logic arst_n,
	output logic tick_250us,		// Two pulses per 500us period
	output logic tick_10us			// Index reference
);

	localparam logic [15:0] half_last = 16'(`TICK_250US_DIV - 1);
	localparam logic [15:0] full_last = 16'(2 * `TICK_250US_DIV - 1);
	localparam logic [15:0] ref_last  = 16'(`TICK_10US_DIV - 1);

	logic [15:0] step_cnt;			// Counts over 500us
	logic [15:0] ref_cnt;			// Counts over 10us

	// 500us counter, extra pulse at mid-count
	always_ff @(posedge CLK_MASTER or negedge arst_n) begin
		if (!arst_n) begin
			step_cnt   <= '0;
			tick_250us <= 1'b0;
		end else begin
			step_cnt   <= (step_cnt == full_last) ? 16'd0 : step_cnt + 16'd1;
			tick_250us <= (step_cnt == full_last) || (step_cnt == half_last);
		end
	end

	always_ff @(posedge CLK_MASTER or negedge arst_n) begin
		if (!arst_n) begin
			ref_cnt   <= '0;
			tick_10us <= 1'b0;
		end else begin
			ref_cnt   <= (ref_cnt == ref_last) ? 16'd0 : ref_cnt + 16'd1;
			tick_10us <= (ref_cnt == ref_last);		// One cycle at wrap
		end
	end

endmodule

// File: tests/fdd_assert.sv
`timescale 1ns/100ps

module fdd_assert (
	input logic        CLK_MASTER,
	input logic        arst_n,
	input logic        sram_we_n,
	input logic        sram_oe_n,
	input logic        fd_step_n,
	input logic        is_stepping,
	input logic [18:0] sram_a,
	input logic        incr,
	input logic        rd_done,
	input logic [2:0]  addr_load
);

	// SRAM never driven from both sides
	we_oe_excl: assert property (@(posedge CLK_MASTER) disable iff (!arst_n)
		!(!sram_we_n && !sram_oe_n))
		else $error("sram_we_n and sram_oe_n both low");

	// A step pulse starts only while steps remain
	step_in_seek: assert property (@(posedge CLK_MASTER) disable iff (!arst_n)
		$fell(fd_step_n) |-> $past(is_stepping))
		else $error("fd_step_n fell outside a seek");

	// Address moves only after a step or a load request
	addr_moves: assert property (@(posedge CLK_MASTER) disable iff (!arst_n)
		(sram_a != $past(sram_a)) |-> $past(incr | rd_done | (|addr_load)))
		else $error("sram_a changed without increment or load");

endmodule

bind fdd_top fdd_assert u_assert (
	.CLK_MASTER		(CLK_MASTER),
	.arst_n			(arst_n),
	.sram_we_n		(sram_we_n),
	.sram_oe_n		(sram_oe_n),
	.fd_step_n		(fd_step_n),
	.is_stepping	(is_stepping),
	.sram_a			(sram_a),
	.incr			(incr),
	.rd_done		(rd_done),
	.addr_load		(addr_load)
);

// File: tests/fdd_checker.sv
`timescale 1ns/100ps
`include "fdd_settings.svh"

module fdd_checker (
	input  logic        CLK_MASTER,
	input  logic        arst_n,
	input  logic        fd_step_n,
	input  logic        fd_dir,
	input  logic        chk_stb,		// One cycle per record
	input  logic [3:0]  chk_kind,
	input  logic [31:0] chk_arg,
	input  logic [31:0] chk_arg2,
	input  logic [31:0] chk_got,
	output int          err_cnt
);

	int   checks = 0;
	int   test_checks = 0;
	int   test_errs = 0;
	int   step_cnt = 0;			// Step pulses seen since last clear
	logic last_dir = 1'b0;
	logic step_prev = 1'b1;

	initial err_cnt = 0;

	////////////////////////////////////////////////////////////////////////////
	// Reference model

	function automatic logic [7:0] readback_value(input logic [7:0] r, input logic [31:0] a);
		case (r)
			`REG_ADDR_LOW:         return a[7:0];
			`REG_ADDR_HIGH:        return a[15:8];
			`REG_ADDR_UPPER:       return {5'd0, a[18:16]};
			`REG_DRIVE_CTL:        return 8'h55;		// Type low
			`REG_DRIVE_CTL + 8'd1: return 8'hDD;
			`REG_DRIVE_CTL + 8'd2: return 8'h28;		// Version low
			`REG_DRIVE_CTL + 8'd3: return 8'h00;
			`REG_SCRATCH:          return a[7:0];
			`REG_SCRATCH_INV:      return ~a[7:0];
			`REG_FIXED_55:         return 8'h55;
			`REG_FIXED_AA:         return 8'hAA;
			default:               return 8'h00;
		endcase
	endfunction

	// Power-up memory pattern, every address bit involved
	function automatic logic [7:0] fill_pattern(input logic [18:0] a);
		return a[7:0] ^ a[15:8] ^ {a[18:16], 5'b10101};
	endfunction

	function automatic int steps_taken(input int n, input int k);
		return (k < n) ? k : n;		// Track 0 cuts the seek short
	endfunction

	function automatic string test_name(input int n);
		case (n)
			1: return "register read-back";
			2: return "address load";
			3: return "SRAM writes";
			4: return "SRAM reads";
			5: return "index measurement";
			6: return "stepping";
			default: return "unknown";
		endcase
	endfunction

	task automatic compare(input string what, input longint exp, input longint got, input int tol);
		longint diff;
		diff = (exp > got) ? exp - got : got - exp;
		checks++;
		test_checks++;
		if (diff > tol) begin
			err_cnt++;
			test_errs++;
			$display("ERR %0t: %s expected %0h got %0h", $time, what, exp, got);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Step pulse watch and record comparison

	always @(posedge CLK_MASTER) begin
		step_prev <= fd_step_n;
		if (arst_n && step_prev && !fd_step_n) begin
			step_cnt <= step_cnt + 1;
			last_dir <= fd_dir;		// Direction at each pulse
		end
		if (chk_stb) begin
			case (chk_kind)
				4'd0: compare("read-back", readback_value(chk_arg[7:0], chk_arg2), chk_got, 0);
				4'd1: compare("drive outputs", {24'd0, ~chk_arg[7:0]}, chk_got, 0);
				4'd2: compare("value", chk_arg, chk_got, 0);
				4'd3: compare("SRAM fill", fill_pattern(chk_arg[18:0]), chk_got, 0);
				4'd4: compare("address", (chk_arg + chk_arg2) & 32'h7FFFF, chk_got, 0);
				4'd5: compare("index count", chk_arg / chk_arg2, chk_got, 1);	// +-1 tick
				4'd6: step_cnt <= 0;
				4'd7: compare("step count", steps_taken(chk_arg, chk_arg2), step_cnt, 0);
				4'd8: compare("step direction", chk_arg, last_dir, 0);
				4'd9: begin
					$display("Test %0d %s: %0d checks, %0d errors", chk_arg,
						test_name(chk_arg), test_checks, test_errs);
					test_checks = 0;
					test_errs = 0;
				end
				4'd10: begin
					err_cnt++;				// Reported by the testbench in words
					test_errs++;
				end
				default: $display("Summary: %0d checks, %0d errors", checks, err_cnt);
			endcase
		end
	end

endmodule

// File: tests/fdd_tb.sv
`timescale 1ns/100ps
`include "fdd_settings.svh"

module fdd_tb;

	localparam int idx_period = 23 * `TICK_10US_DIV;	// Index period in cycles
	localparam int bus_len    = 200 * 15;				// Bus accesses
	localparam int step_len   = 20 * 2 * `TICK_250US_DIV;
	localparam int limit      = bus_len + 4 * idx_period + step_len + 20_000;

	logic        CLK_MASTER = 1'b0;
	logic        arst_n = 1'b0;
	logic [7:0]  mcu_pmd_in = '0, mcu_pmd_out;
	logic        mcu_pmall = 1'b0, mcu_pmwr = 1'b0, mcu_pmrd = 1'b0;
	logic [18:0] sram_a;
	logic [7:0]  sram_dq_in, sram_dq_out;
	logic        sram_we_n, sram_oe_n;
	logic        fd_dens_out, fd_inuse, fd_moten, fd_sidesel, fd_dir, fd_step_n;
	logic [3:0]  fd_drvsel;
	logic        fd_index_in = 1'b0, fd_track0_in = 1'b0;
	logic        fd_wrprot_in = 1'b1, fd_rdy_in = 1'b1, fd_dens_in = 1'b0;
	logic        chk_stb = 1'b0;
	logic [3:0]  chk_kind = '0;
	logic [31:0] chk_arg = '0, chk_arg2 = '0, chk_got = '0;
	int          err_cnt;
	int          seed = 32'h5bb1_3df0;
	logic [7:0]  mem [0:524287];		// 512Kx8 SRAM model

	fdd_top dut (.*);

	fdd_checker chk (.*);

	initial begin
		forever #2 CLK_MASTER = ~CLK_MASTER;
	end

	// SRAM model, async read and write on the strobe
	assign sram_dq_in = mem[sram_a];
	always @(posedge CLK_MASTER)
		if (!sram_we_n)
			mem[sram_a] <= sram_dq_out;

	initial begin
		repeat (limit) @(posedge CLK_MASTER);
		$display("Timeout: run still going after %0d cycles", limit);
		$display("Errors found");
		$finish;
	end

	////////////////////////////////////////////////////////////////////////////
	// Bus and checker tasks

	task automatic latch_addr(input logic [7:0] a);
		@(negedge CLK_MASTER);
		mcu_pmd_in = a;
		mcu_pmall = 1'b1;
		repeat (3) @(negedge CLK_MASTER);
		mcu_pmall = 1'b0;
		repeat (3) @(negedge CLK_MASTER);
	endtask

	task automatic bus_write(input logic [7:0] a, input logic [7:0] d);
		latch_addr(a);
		mcu_pmd_in = d;
		mcu_pmwr = 1'b1;
		repeat (3) @(negedge CLK_MASTER);
		mcu_pmwr = 1'b0;
		repeat (3) @(negedge CLK_MASTER);
	endtask

	task automatic bus_read(input logic [7:0] a, output logic [7:0] d);
		latch_addr(a);
		mcu_pmrd = 1'b1;
		repeat (3) @(negedge CLK_MASTER);
		d = mcu_pmd_out;			// Stable while the strobe is high
		mcu_pmrd = 1'b0;
		repeat (3) @(negedge CLK_MASTER);
	endtask

	task automatic post(input int kind, input logic [31:0] a, input logic [31:0] a2,
		input logic [31:0] got);
		chk_kind = 4'(kind);
		chk_arg = a;
		chk_arg2 = a2;
		chk_got = got;
		chk_stb = 1'b1;
		@(negedge CLK_MASTER);
		chk_stb = 1'b0;
	endtask

	task automatic load_addr(input logic [18:0] a);
		bus_write(`REG_ADDR_LOW, a[7:0]);
		bus_write(`REG_ADDR_HIGH, a[15:8]);
		bus_write(`REG_ADDR_UPPER, {5'd0, a[18:16]});
	endtask

	task automatic read_addr(output logic [18:0] a);
		logic [7:0] lo, hi, up;
		bus_read(`REG_ADDR_LOW, lo);
		bus_read(`REG_ADDR_HIGH, hi);
		bus_read(`REG_ADDR_UPPER, up);
		a = {up[2:0], hi, lo};
	endtask

	// Polls a DUT busy level with a cycle budget
	task automatic wait_idle(input int which, input int budget);
		int n;
		n = 0;
		while ((which == 0 ? dut.fifo_busy : dut.is_stepping) && n < budget) begin
			@(negedge CLK_MASTER);
			n++;
		end
		if (n >= budget) begin
			$display("%s did not fall within %0d cycles",
				which == 0 ? "fifo_busy" : "is_stepping", budget);
			post(10, 0, 0, 0);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Test sequence

	initial begin
		logic [7:0]  v, hi, lo, sc, dc;
		logic [18:0] a, b, got_a;
		logic [7:0]  wd [6];
		int          n;

		for (int i = 0; i < 524288; i++)
			mem[i] = 8'(i) ^ 8'(i >> 8) ^ {3'(i >> 16), 5'b10101};
		repeat (8) @(negedge CLK_MASTER);
		arst_n = 1'b1;
		repeat (2) @(negedge CLK_MASTER);

		// Idle SRAM strobes after reset
		post(2, 1, 0, sram_we_n);
		post(2, 0, 0, sram_oe_n);

		// 1: ID bytes, patterns, scratchpad, drive outputs
		for (int i = 0; i < 4; i++) begin
			bus_read(`REG_DRIVE_CTL + 8'(i), v);
			post(0, `REG_DRIVE_CTL + i, 0, v);
		end
		bus_read(`REG_FIXED_55, v);
		post(0, `REG_FIXED_55, 0, v);
		bus_read(`REG_FIXED_AA, v);
		post(0, `REG_FIXED_AA, 0, v);
		sc = 8'($random(seed));
		bus_write(`REG_SCRATCH, sc);
		bus_read(`REG_SCRATCH, v);
		post(0, `REG_SCRATCH, sc, v);
		bus_read(`REG_SCRATCH_INV, v);
		post(0, `REG_SCRATCH_INV, sc, v);
		dc = 8'($random(seed));
		bus_write(`REG_DRIVE_CTL, dc);
		post(1, dc, 0, {fd_sidesel, fd_moten, fd_drvsel, fd_inuse, fd_dens_out});
		post(9, 1, 0, 0);

		// 2: address bytes, empty and full
		a = 19'($random(seed));
		load_addr(a);
		bus_read(`REG_ADDR_LOW, v);
		post(0, `REG_ADDR_LOW, a, v);
		bus_read(`REG_ADDR_HIGH, v);
		post(0, `REG_ADDR_HIGH, a, v);
		bus_read(`REG_ADDR_UPPER, v);
		post(0, `REG_ADDR_UPPER, a, v);
		load_addr(19'd0);
		bus_read(`REG_STATUS2, v);
		post(2, 1, 0, v[1]);
		load_addr(19'h7FFFF);
		bus_read(`REG_STATUS2, v);
		post(2, 1, 0, v[0]);
		post(9, 2, 0, 0);

		// 3: write burst through the FIFO
		a = 19'($random(seed));
		load_addr(a);
		for (int i = 0; i < 6; i++) begin
			wd[i] = 8'($random(seed));
			bus_write(`REG_SRAM_DATA, wd[i]);
		end
		wait_idle(0, 200);
		for (int i = 0; i < 6; i++)
			post(2, wd[i], 0, mem[19'(a + 19'(i))]);
		read_addr(got_a);
		post(4, a, 6, got_a);
		post(9, 3, 0, 0);

		// 4: read-back in address order, other half of memory
		b = a ^ 19'h40000;
		load_addr(b);
		for (int i = 0; i < 6; i++) begin
			bus_read(`REG_SRAM_DATA, v);
			post(3, 19'(b + 19'(i)), 0, v);
		end
		post(9, 4, 0, 0);

		// 5: three index edges, last period measured
		for (int i = 0; i < 3; i++) begin
			fd_index_in = 1'b1;
			repeat (20) @(negedge CLK_MASTER);
			fd_index_in = 1'b0;
			repeat (idx_period - 20) @(negedge CLK_MASTER);
		end
		bus_read(`REG_STATUS1, v);
		post(2, 1, 0, v[3]);
		bus_read(`REG_INDEX_HI, hi);
		bus_read(`REG_INDEX_LO, lo);
		post(5, idx_period, `TICK_10US_DIV, {hi, lo});
		bus_read(`REG_STATUS1, v);
		post(2, 0, 0, v[3]);
		post(9, 5, 0, 0);

		// 6: inward seek, then outward seek stopped by track 0
		bus_write(`REG_STEP_RATE, 8'd0);
		n = 1 + int'(unsigned'($random(seed)) % 6);
		post(6, 0, 0, 0);
		bus_write(`REG_STEP_CMD, {1'b1, 7'(n)});
		wait_idle(1, (n + 2) * 2 * `TICK_250US_DIV);
		post(7, n, 127, 0);
		post(8, 1, 0, 0);
		post(6, 0, 0, 0);
		bus_write(`REG_STEP_CMD, {1'b0, 7'd5});
		repeat (2) @(posedge fd_step_n);		// k = 2 pulses out
		@(negedge CLK_MASTER);
		fd_track0_in = 1'b1;
		wait_idle(1, 4 * 2 * `TICK_250US_DIV);
		post(7, 5, 2, 0);
		post(8, 0, 0, 0);
		bus_read(`REG_STATUS1, v);
		post(2, 1, 0, v[4]);					// track0_hit
		bus_read(`REG_STATUS2, v);
		post(2, 0, 0, v[2]);					// is_stepping
		fd_track0_in = 1'b0;
		post(9, 6, 0, 0);

		post(11, 0, 0, 0);
		@(negedge CLK_MASTER);
		if (err_cnt == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule
